// File: memory_pkg.sv
/* widths, cache size, root table PPN and PTE field positions
   shared by the walkers, the translation path caches and the page-table memory */
package memory_pkg;

  // virtual page number, split in three 9 bit level indices
  localparam int VPN_PART_LEN = 9;
  localparam int PT_LEVELS    = 3;
  localparam int VPN_LEN      = PT_LEVELS * VPN_PART_LEN; // vpn2 | vpn1 | vpn0

  localparam int PPN_LEN = 44; // physical page number

  // page-table entry layout
  localparam int PTE_LEN       = 64;
  localparam int PTE_VALID_BIT = 0;
  localparam int PTE_LEAF_BIT  = 1;
  localparam int PTE_PPN_LSB   = 10; // ppn sits in bits 53..10

  // translation path cache
  localparam int MMUC_ENTRIES = 4;
  localparam int MMUC_TAG_LEN = 2 * VPN_PART_LEN; // vpn2 and vpn1 of a walk

  // page-table memory, word addressed
  localparam int PT_ADDR_LEN = 10;
  // table ppn bits that survive in a memory address
  localparam int PT_TBL_LEN  = PT_ADDR_LEN - VPN_PART_LEN;

  // root table, fixed since there is no satp
  localparam logic [PPN_LEN-1:0] ROOT_PPN = 44'h000_0000_0000;

endpackage

// File: tpc_regfile.sv
/* storage of the translation path cache: two tag/data pairs per line,
   plus partial and valid bits, with side-selective writes and flush */
`timescale 1ns/10ps

module tpc_regfile #(
  parameter int ADDR_LEN = memory_pkg::MMUC_ENTRIES // number of lines
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic                                                   wr_en_i,      // write one side
  input  logic                                                   wr_part_en_i, // complete line
  input  logic [memory_pkg::VPN_PART_LEN-1:0]                    tag_i,
  input  logic [memory_pkg::PPN_LEN-1:0]                         data_i,
  input  logic                                                   partial_i,
  input  logic                                                   flush_i,
  input  logic [ADDR_LEN-1:0]                                    decoded_waddr_i, // one-hot
  input  logic                                                   which_side_i,
  output logic [ADDR_LEN-1:0][1:0][memory_pkg::VPN_PART_LEN-1:0] tag_vec_o,
  output logic [ADDR_LEN-1:0][1:0][memory_pkg::PPN_LEN-1:0]      data_vec_o,
  output logic [ADDR_LEN-1:0]                                    partial_vec_o,
  output logic [ADDR_LEN-1:0]                                    valid_vec_o
);

  logic [ADDR_LEN-1:0][1:0][memory_pkg::VPN_PART_LEN-1:0] tag_q;
  logic [ADDR_LEN-1:0][1:0][memory_pkg::PPN_LEN-1:0]      data_q;
  logic [ADDR_LEN-1:0]                                    partial_q;
  logic [ADDR_LEN-1:0]                                    valid_q;

  // payload, side 1 holds the vpn2 step and side 0 the vpn1 step
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < ADDR_LEN; k++) begin
      if (decoded_waddr_i[k]) begin
        if (wr_en_i) begin
          tag_q[k][which_side_i]  <= tag_i;
          data_q[k][which_side_i] <= data_i;
          partial_q[k]            <= partial_i;
        end else if (wr_part_en_i) begin // second step of the trace
          tag_q[k][0]  <= tag_i;
          data_q[k][0] <= data_i;
          partial_q[k] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0; // flush wins over a write in the same cycle
    end else if (wr_en_i) begin
      valid_q <= valid_q | decoded_waddr_i;
    end
  end

  assign tag_vec_o     = tag_q;
  assign data_vec_o    = data_q;
  assign partial_vec_o = partial_q;
  assign valid_vec_o   = valid_q;

endmodule

// File: tpc_comp_block.sv
/* compare of the vpn2/vpn1 lookup tag against every cache line,
   giving hit, full hit and a hit vector that prefers full hits */
`timescale 1ns/10ps

module tpc_comp_block #(
  parameter int REG_ENTRIES  = memory_pkg::MMUC_ENTRIES,
  parameter int HALF_TAG_LEN = memory_pkg::VPN_PART_LEN
) (
  input  logic [1:0][HALF_TAG_LEN-1:0]                   tag_i,     // [1] vpn2, [0] vpn1
  input  logic [REG_ENTRIES-1:0][1:0][HALF_TAG_LEN-1:0] tag_vec_i,
  input  logic [REG_ENTRIES-1:0]                        partial_vec_i,
  input  logic [REG_ENTRIES-1:0]                        valid_vec_i,
  output logic                                          hit_o,      // vpn2 matched somewhere
  output logic                                          full_hit_o, // both levels matched
  output logic [REG_ENTRIES-1:0]                        hit_vec_o
);

  logic [REG_ENTRIES-1:0] part_vec; // lines matching on vpn2
  logic [REG_ENTRIES-1:0] full_vec; // lines matching on vpn2 and vpn1

  always_comb begin
    for (int k = 0; k < REG_ENTRIES; k++) begin
      part_vec[k] = valid_vec_i[k] && (tag_vec_i[k][1] == tag_i[1]);
      // a partial line has no valid vpn1 step yet
      full_vec[k] = part_vec[k] && !partial_vec_i[k] && (tag_vec_i[k][0] == tag_i[0]);
    end
  end

  assign hit_o      = |part_vec;
  assign full_hit_o = |full_vec;
  assign hit_vec_o  = full_hit_o ? full_vec : part_vec; // full-hit lines first

endmodule

// File: mmu_cache.sv
/* translation path cache: regfile and compare block, hit registers,
   FIFO replacement pointer, write address mux and ppn selection */
`timescale 1ns/10ps

module mmu_cache (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     req_valid_i,  // lookup strobe
  input  logic [1:0][memory_pkg::VPN_PART_LEN-1:0] tags_i,       // [1] vpn2, [0] vpn1
  input  logic                                     wr_en_i,
  input  logic                                     wr_partial_i, // complete the line
  input  logic                                     which_side_i,
  input  logic [memory_pkg::VPN_PART_LEN-1:0]      wtag_i,
  input  logic [memory_pkg::PPN_LEN-1:0]           wdata_i,
  input  logic                                     wpartial_i,
  input  logic                                     try_update_i, // once per missed walk
  input  logic                                     flush_i,
  output logic [memory_pkg::PPN_LEN-1:0]           ppn_o,
  output logic                                     hit_o,
  output logic                                     full_hit_o
);

  logic [memory_pkg::MMUC_ENTRIES-1:0][1:0][memory_pkg::VPN_PART_LEN-1:0] tag_vec;
  logic [memory_pkg::MMUC_ENTRIES-1:0][1:0][memory_pkg::PPN_LEN-1:0]      data_vec;
  logic [memory_pkg::MMUC_ENTRIES-1:0] partial_vec;
  logic [memory_pkg::MMUC_ENTRIES-1:0] valid_vec;
  logic [memory_pkg::MMUC_ENTRIES-1:0] dec_waddr;    // one-hot write select
  logic [memory_pkg::MMUC_ENTRIES-1:0] hit_vec_d, hit_vec_q;
  logic [memory_pkg::MMUC_ENTRIES-1:0] replace_vec_q; // FIFO pointer, one-hot
  logic                                hit_d, hit_q;
  logic                                full_hit;
  logic                                update_fifo;
  logic [1:0][memory_pkg::PPN_LEN-1:0] sel_ppns;     // trace of the selected line

  tpc_regfile #(
    .ADDR_LEN(memory_pkg::MMUC_ENTRIES)
  ) i_regfile (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wr_en_i        (wr_en_i),
    .wr_part_en_i   (wr_partial_i),
    .tag_i          (wtag_i),
    .data_i         (wdata_i),
    .partial_i      (wpartial_i),
    .flush_i        (flush_i),
    .decoded_waddr_i(dec_waddr),
    .which_side_i   (which_side_i),
    .tag_vec_o      (tag_vec),
    .data_vec_o     (data_vec),
    .partial_vec_o  (partial_vec),
    .valid_vec_o    (valid_vec)
  );

  tpc_comp_block #(
    .REG_ENTRIES (memory_pkg::MMUC_ENTRIES),
    .HALF_TAG_LEN(memory_pkg::MMUC_TAG_LEN / 2)
  ) i_comp (
    .tag_i        (tags_i),
    .tag_vec_i    (tag_vec),
    .partial_vec_i(partial_vec),
    .valid_vec_i  (valid_vec),
    .hit_o        (hit_d),
    .full_hit_o   (full_hit),
    .hit_vec_o    (hit_vec_d)
  );

  assign update_fifo = try_update_i & ~hit_q; // a hit line is refreshed in place

  // hit state of the last lookup picks the line for later writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_q     <= 1'b0;
      hit_vec_q <= '0;
    end else if (req_valid_i) begin
      hit_q     <= hit_d;
      hit_vec_q <= hit_vec_d;
    end else if (update_fifo) begin
      // keep pointing at the victim so the vpn1 step lands in the same line
      hit_q     <= 1'b1;
      hit_vec_q <= replace_vec_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      replace_vec_q <= memory_pkg::MMUC_ENTRIES'(1); // entry 0 first
    end else if (update_fifo) begin
      replace_vec_q <= {replace_vec_q[0], replace_vec_q[memory_pkg::MMUC_ENTRIES-1:1]};
    end
  end

  assign dec_waddr = hit_q ? hit_vec_q : replace_vec_q;

  // lowest index line that hit
  always_comb begin
    sel_ppns = data_vec[0];
    for (int k = memory_pkg::MMUC_ENTRIES - 1; k >= 0; k--) begin
      if (hit_vec_d[k]) sel_ppns = data_vec[k];
    end
  end

  assign ppn_o      = full_hit ? sel_ppns[0] : sel_ppns[1]; // level-0 or level-1 table
  assign hit_o      = hit_d;
  assign full_hit_o = full_hit;

endmodule

// File: ptw.sv
/* page table walker: cache lookup, level skipping, reads through the
   arbiter, cache fill on pointer reads, leaf and fault reporting */
`timescale 1ns/10ps

module ptw (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  input  logic                               req_i,     // start pulse
  input  logic [memory_pkg::VPN_LEN-1:0]     vpn_i,
  input  logic                               rvalid_i,
  input  logic [memory_pkg::PTE_LEN-1:0]     rdata_i,
  output logic                               busy_o,
  output logic                               done_o,
  output logic [memory_pkg::PPN_LEN-1:0]     ppn_o,
  output logic                               superpage_o,
  output logic                               fault_o,
  output logic                               rd_req_o,  // held until served
  output logic [memory_pkg::PT_ADDR_LEN-1:0] rd_addr_o
);

  typedef enum logic [1:0] {S_IDLE, S_LOOKUP, S_READ} state_t;

  state_t                                   state_q;
  logic [memory_pkg::VPN_LEN-1:0]           vpn_q;
  logic [1:0]                               lvl_q, start_lvl, cur_lvl;
  logic [memory_pkg::PT_TBL_LEN-1:0]        tbl_q, cur_tbl;
  logic                                     first_q;  // no cache write yet in this walk
  logic [memory_pkg::PPN_LEN-1:0]           mmuc_ppn, start_tbl, pte_ppn;
  logic                                     mmuc_req, mmuc_hit, mmuc_full_hit;
  logic [1:0][memory_pkg::VPN_PART_LEN-1:0] mmuc_tags;
  logic                                     pte_valid, pte_leaf, ptr_rd, finish;
  logic                                     wr_en, wr_partial, top_lvl;

  mmu_cache i_mmuc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (mmuc_req),
    .tags_i      (mmuc_tags),
    .wr_en_i     (wr_en),
    .wr_partial_i(wr_partial),
    .which_side_i(top_lvl),
    .wtag_i      (vpn_q[lvl_q*memory_pkg::VPN_PART_LEN +: memory_pkg::VPN_PART_LEN]),
    .wdata_i     (pte_ppn),
    .wpartial_i  (top_lvl),
    .try_update_i((wr_en | wr_partial) & first_q),
    .flush_i     (flush_i),
    .ppn_o       (mmuc_ppn),
    .hit_o       (mmuc_hit),
    .full_hit_o  (mmuc_full_hit)
  );

  assign mmuc_req  = (state_q == S_LOOKUP);
  assign mmuc_tags = vpn_q[memory_pkg::VPN_LEN-1 -: memory_pkg::MMUC_TAG_LEN];

  // where the walk starts: level 0 on full hit, 1 on partial, root otherwise
  assign start_lvl = mmuc_full_hit ? 2'd0 : mmuc_hit ? 2'd1 : 2'(memory_pkg::PT_LEVELS - 1);
  assign start_tbl = mmuc_hit ? mmuc_ppn : memory_pkg::ROOT_PPN;

  // the first read goes out in the lookup cycle
  assign cur_lvl   = mmuc_req ? start_lvl : lvl_q;
  assign cur_tbl   = mmuc_req ? start_tbl[memory_pkg::PT_TBL_LEN-1:0] : tbl_q;
  assign rd_req_o  = (state_q == S_LOOKUP) || (state_q == S_READ);
  assign rd_addr_o = {cur_tbl, vpn_q[cur_lvl*memory_pkg::VPN_PART_LEN +: memory_pkg::VPN_PART_LEN]};

  // pte decode
  assign pte_valid = rdata_i[memory_pkg::PTE_VALID_BIT];
  assign pte_leaf  = rdata_i[memory_pkg::PTE_LEAF_BIT];
  assign pte_ppn   = rdata_i[memory_pkg::PTE_PPN_LSB +: memory_pkg::PPN_LEN];

  assign ptr_rd  = (state_q == S_READ) && rvalid_i && pte_valid && !pte_leaf && (lvl_q != 2'd0);
  assign finish  = (state_q == S_READ) && rvalid_i && !ptr_rd; // leaf, invalid or bad level 0
  assign top_lvl = (lvl_q == 2'(memory_pkg::PT_LEVELS - 1));

  // vpn2 step opens a partial line, vpn1 step completes it
  assign wr_en      = ptr_rd & top_lvl;
  assign wr_partial = ptr_rd & ~top_lvl;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      lvl_q   <= '0;
      tbl_q   <= '0;
      first_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: if (req_i) state_q <= S_LOOKUP;
        S_LOOKUP: begin
          state_q <= S_READ;
          lvl_q   <= start_lvl;
          tbl_q   <= start_tbl[memory_pkg::PT_TBL_LEN-1:0];
          first_q <= 1'b1;
        end
        S_READ: if (rvalid_i) begin
          first_q <= 1'b0;
          if (finish) begin
            state_q <= S_IDLE;
          end else begin // descend one level
            lvl_q <= lvl_q - 2'd1;
            tbl_q <= pte_ppn[memory_pkg::PT_TBL_LEN-1:0];
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && req_i) vpn_q <= vpn_i; // payload only
  end

  assign busy_o      = (state_q != S_IDLE);
  assign done_o      = finish;
  assign fault_o     = !(pte_valid && pte_leaf);
  assign superpage_o = pte_valid && pte_leaf && (lvl_q != 2'd0);

  // superpage, low vpn parts fill the ppn below the leaf level
  always_comb begin
    ppn_o = pte_ppn;
    for (int k = 0; k < memory_pkg::PT_LEVELS - 1; k++) begin
      if (lvl_q > k) begin
        ppn_o[k*memory_pkg::VPN_PART_LEN +: memory_pkg::VPN_PART_LEN] =
          vpn_q[k*memory_pkg::VPN_PART_LEN +: memory_pkg::VPN_PART_LEN];
      end
    end
  end

endmodule

// File: pt_arbiter.sv
/* round-robin arbiter of the two walkers onto the page-table read port */
`timescale 1ns/10ps

module pt_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [1:0]                               req_i,   // [0] i-side, [1] d-side
  input  logic [1:0][memory_pkg::PT_ADDR_LEN-1:0] addr_i,
  output logic [1:0]                               gnt_o,
  output logic [1:0]                               rvalid_o, // one cycle after gnt_o
  output logic [memory_pkg::PT_ADDR_LEN-1:0]       addr_o,
  output logic                                     rd_en_o
);

  logic       last_q; // last winner
  logic [1:0] gnt_q;
  logic [1:0] req_m;

  // a walker still holds its request while its data returns, skip it then
  assign req_m = req_i & ~gnt_q;

  always_comb begin
    if (&req_m) gnt_o = last_q ? 2'b01 : 2'b10; // the other side goes first
    else        gnt_o = req_m;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= 1'b0;
      gnt_q  <= '0;
    end else begin
      gnt_q <= gnt_o;
      if (|gnt_o) last_q <= gnt_o[1];
    end
  end

  assign rvalid_o = gnt_q; // memory answers one cycle after the grant
  assign addr_o   = gnt_o[1] ? addr_i[1] : addr_i[0];
  assign rd_en_o  = |gnt_o;

endmodule

// File: pt_mem.sv
/* page-table memory, one-cycle read port and host write port */
`timescale 1ns/10ps

module pt_mem (
  input  logic                               clk_i,
  input  logic                               rd_en_i,
  input  logic [memory_pkg::PT_ADDR_LEN-1:0] rd_addr_i,
  output logic [memory_pkg::PTE_LEN-1:0]     rdata_o,
  input  logic                               we_i,     // host fill
  input  logic [memory_pkg::PT_ADDR_LEN-1:0] waddr_i,
  input  logic [memory_pkg::PTE_LEN-1:0]     wdata_i
);

  logic [memory_pkg::PTE_LEN-1:0] mem_q [2**memory_pkg::PT_ADDR_LEN];

  always_ff @(posedge clk_i) begin
    if (we_i) mem_q[waddr_i] <= wdata_i;
  end

  // read before write on the same address
  always_ff @(posedge clk_i) begin
    if (rd_en_i) rdata_o <= mem_q[rd_addr_i];
  end

endmodule

// File: ptw_top.sv
/* two walker and cache pairs sharing one page-table memory through the arbiter */
`timescale 1ns/10ps

module ptw_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,    // both caches
  input  logic                               pt_we_i,
  input  logic [memory_pkg::PT_ADDR_LEN-1:0] pt_waddr_i,
  input  logic [memory_pkg::PTE_LEN-1:0]     pt_wdata_i,
  // instruction side
  input  logic                               i_req_i,
  input  logic [memory_pkg::VPN_LEN-1:0]     i_vpn_i,
  output logic                               i_busy_o,
  output logic                               i_done_o,
  output logic [memory_pkg::PPN_LEN-1:0]     i_ppn_o,
  output logic                               i_superpage_o,
  output logic                               i_fault_o,
  // data side
  input  logic                               d_req_i,
  input  logic [memory_pkg::VPN_LEN-1:0]     d_vpn_i,
  output logic                               d_busy_o,
  output logic                               d_done_o,
  output logic [memory_pkg::PPN_LEN-1:0]     d_ppn_o,
  output logic                               d_superpage_o,
  output logic                               d_fault_o
);

  logic [1:0]                               rd_req, rvalid; // [0] i, [1] d
  logic [1:0][memory_pkg::PT_ADDR_LEN-1:0] rd_addr;
  logic [memory_pkg::PT_ADDR_LEN-1:0]       mem_addr;
  logic                                     mem_rd_en;
  logic [memory_pkg::PTE_LEN-1:0]           rdata;   // shared by both walkers

  ptw i_ptw_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
    .req_i(i_req_i), .vpn_i(i_vpn_i), .rvalid_i(rvalid[0]), .rdata_i(rdata),
    .busy_o(i_busy_o), .done_o(i_done_o), .ppn_o(i_ppn_o),
    .superpage_o(i_superpage_o), .fault_o(i_fault_o),
    .rd_req_o(rd_req[0]), .rd_addr_o(rd_addr[0])
  );

  ptw i_ptw_d (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
    .req_i(d_req_i), .vpn_i(d_vpn_i), .rvalid_i(rvalid[1]), .rdata_i(rdata),
    .busy_o(d_busy_o), .done_o(d_done_o), .ppn_o(d_ppn_o),
    .superpage_o(d_superpage_o), .fault_o(d_fault_o),
    .rd_req_o(rd_req[1]), .rd_addr_o(rd_addr[1])
  );

  pt_arbiter i_arb (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_i(rd_req), .addr_i(rd_addr),
    .gnt_o(), .rvalid_o(rvalid), .addr_o(mem_addr), .rd_en_o(mem_rd_en)
  );

  pt_mem i_mem (
    .clk_i(clk_i), .rd_en_i(mem_rd_en), .rd_addr_i(mem_addr), .rdata_o(rdata),
    .we_i(pt_we_i), .waddr_i(pt_waddr_i), .wdata_i(pt_wdata_i)
  );

endmodule

// File: tb_ptw_top.sv
/* testbench of the two-walker translation subsystem: random page tables, random
   translations on both sides, a walk and cache reference model, and checks */
`timescale 1ns/10ps

module tb_ptw_top;

  localparam int N_SOLO    = 60;  // requests per side with the other side quiet
  localparam int N_DUAL    = 120; // requests per side with both sides active
  localparam int N_REQ     = 4 * N_SOLO + 6 * N_DUAL;
  localparam int WD_CYCLES = 20 * N_REQ + 2 * (2 ** memory_pkg::PT_ADDR_LEN) + 50;

  logic clk_i = 1'b0;
  logic rst_ni, flush_i, pt_we_i, i_req_i, d_req_i;
  logic [memory_pkg::PT_ADDR_LEN-1:0] pt_waddr_i;
  logic [memory_pkg::PTE_LEN-1:0]     pt_wdata_i;
  logic [memory_pkg::VPN_LEN-1:0]     i_vpn_i, d_vpn_i;
  logic i_busy_o, i_done_o, i_superpage_o, i_fault_o;
  logic d_busy_o, d_done_o, d_superpage_o, d_fault_o;
  logic [memory_pkg::PPN_LEN-1:0]     i_ppn_o, d_ppn_o;

  integer seed;
  logic [memory_pkg::PTE_LEN-1:0]    mem_m  [2**memory_pkg::PT_ADDR_LEN]; // table copy
  // cache model indexed [side][line][half] where half 1 is the vpn2 step
  bit [memory_pkg::VPN_PART_LEN-1:0] c_tag  [2][memory_pkg::MMUC_ENTRIES][2];
  bit [memory_pkg::PPN_LEN-1:0]      c_data [2][memory_pkg::MMUC_ENTRIES][2];
  bit                                c_part [2][memory_pkg::MMUC_ENTRIES];
  bit                                c_val  [2][memory_pkg::MMUC_ENTRIES];
  int                                c_ptr  [2]; // FIFO victim line
  bit [memory_pkg::VPN_PART_LEN-1:0] vpn2_pool [6];
  bit [memory_pkg::VPN_PART_LEN-1:0] vpn1_pool [4];
  bit                                pending [2]; // walk issued and done_o not seen yet

  ptw_top i_dut (.*);

  always #10 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
    fail_run($sformatf("Error at %0t: %s expected %0h got %0h", $time, sig, exp_v, got_v));
  endtask

  task automatic expect_busy(input int s, input logic exp_busy);
    logic got;
    got = (s == 0) ? i_busy_o : d_busy_o;
    assert (got == exp_busy)
      else report_mismatch((s == 0) ? "i_busy_o" : "d_busy_o", exp_busy, got);
  endtask

  // walks the table copy from the cache model's answer and fills the model like the walker
  task automatic model_walk(input int s, input logic [memory_pkg::VPN_LEN-1:0] vpn,
                            output logic [memory_pkg::PPN_LEN-1:0] ppn, output logic sp,
                            output logic flt, output int nrd);
    logic [memory_pkg::VPN_PART_LEN-1:0] part [3];
    logic [memory_pkg::PPN_LEN-1:0]      tbl;
    logic [memory_pkg::PTE_LEN-1:0]      pte;
    logic [memory_pkg::MMUC_ENTRIES-1:0] sel, fsel; // vpn2 matches, full matches
    int                                  lvl;
    for (int k = 0; k < 3; k++) begin
      part[k] = vpn[k*memory_pkg::VPN_PART_LEN +: memory_pkg::VPN_PART_LEN];
    end
    for (int k = 0; k < memory_pkg::MMUC_ENTRIES; k++) begin
      sel[k]  = c_val[s][k] && (c_tag[s][k][1] == part[2]);
      fsel[k] = sel[k] && !c_part[s][k] && (c_tag[s][k][0] == part[1]);
    end
    lvl = 2; // miss starts at the root
    tbl = memory_pkg::ROOT_PPN;
    if (fsel != 0) sel = fsel;
    for (int k = memory_pkg::MMUC_ENTRIES - 1; k >= 0; k--) begin
      if (sel[k]) begin // lowest matching line wins
        lvl = (fsel != 0) ? 0 : 1;
        tbl = c_data[s][k][(fsel != 0) ? 0 : 1];
      end
    end
    nrd = 0;
    forever begin
      pte = mem_m[{tbl[memory_pkg::PT_TBL_LEN-1:0], part[lvl]}];
      nrd++;
      if (!pte[memory_pkg::PTE_VALID_BIT] || pte[memory_pkg::PTE_LEAF_BIT] || lvl == 0) break;
      if (lvl == 2) begin // new partial line at the FIFO victim
        sel = '0;
        sel[c_ptr[s]] = 1'b1;
        c_tag[s][c_ptr[s]][1]  = part[2];
        c_data[s][c_ptr[s]][1] = pte[memory_pkg::PTE_PPN_LSB +: memory_pkg::PPN_LEN];
        c_part[s][c_ptr[s]]    = 1'b1;
        c_val[s][c_ptr[s]]     = 1'b1;
        c_ptr[s] = (c_ptr[s] + memory_pkg::MMUC_ENTRIES - 1) % memory_pkg::MMUC_ENTRIES;
      end else begin
        for (int k = 0; k < memory_pkg::MMUC_ENTRIES; k++) begin
          if (sel[k]) begin // every line that matched vpn2 gets the vpn1 step
            c_tag[s][k][0]  = part[1];
            c_data[s][k][0] = pte[memory_pkg::PTE_PPN_LSB +: memory_pkg::PPN_LEN];
            c_part[s][k]    = 1'b0;
          end
        end
      end
      tbl = pte[memory_pkg::PTE_PPN_LSB +: memory_pkg::PPN_LEN];
      lvl--;
    end
    // invalid entry anywhere, or a pointer left at the last level
    flt = !pte[memory_pkg::PTE_VALID_BIT] || (lvl == 0 && !pte[memory_pkg::PTE_LEAF_BIT]);
    sp  = !flt && (lvl != 0);
    ppn = pte[memory_pkg::PTE_PPN_LSB +: memory_pkg::PPN_LEN];
    for (int k = 0; k < lvl; k++) begin
      ppn[k*memory_pkg::VPN_PART_LEN +: memory_pkg::VPN_PART_LEN] = part[k];
    end
  endtask

  task automatic write_tables();
    logic [memory_pkg::PTE_LEN-1:0] pte;
    logic [2:0]                     kind;
    for (int a = 0; a < 2 ** memory_pkg::PT_ADDR_LEN; a++) begin
      kind = 3'($random(seed));
      pte  = {$random(seed), $random(seed)};
      pte[memory_pkg::PTE_VALID_BIT] = (kind != 3'd7);            // 1 in 8 invalid
      if (kind != 3'd7) pte[memory_pkg::PTE_LEAF_BIT] = (kind >= 3'd5); // 2 in 8 leaves
      mem_m[a] = pte;
      @(posedge clk_i);
      pt_we_i    <= 1'b1;
      pt_waddr_i <= a[memory_pkg::PT_ADDR_LEN-1:0];
      pt_wdata_i <= pte;
    end
    @(posedge clk_i);
    pt_we_i <= 1'b0;
  endtask

  task automatic flush_caches();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < memory_pkg::MMUC_ENTRIES; k++) c_val[s][k] = 1'b0; // ptr stays
    end
  endtask

  function automatic logic [memory_pkg::VPN_LEN-1:0] pick_vpn();
    logic [31:0] r;
    r = $random(seed);
    return {vpn2_pool[r[31:24] % 6], vpn1_pool[r[23:16] % 4],
            r[memory_pkg::VPN_PART_LEN-1:0]};
  endfunction

  task automatic translate(input int s, input logic [memory_pkg::VPN_LEN-1:0] vpn,
                           input bit solo);
    logic [memory_pkg::PPN_LEN-1:0] e_ppn, g_ppn;
    logic                           e_sp, e_flt, g_sp, g_flt;
    int                             nrd, cyc;
    string                          sn;
    sn = (s == 0) ? "i" : "d";
    model_walk(s, vpn, e_ppn, e_sp, e_flt, nrd);
    @(posedge clk_i);
    if (s == 0) begin
      i_req_i <= 1'b1;
      i_vpn_i <= vpn;
    end else begin
      d_req_i <= 1'b1;
      d_vpn_i <= vpn;
    end
    pending[s] = 1'b1;
    @(negedge clk_i); // request cycle, walker still idle
    expect_busy(s, 1'b0);
    @(posedge clk_i);
    if (s == 0) i_req_i <= 1'b0;
    else        d_req_i <= 1'b0;
    cyc = 1;
    @(negedge clk_i); // lookup cycle
    expect_busy(s, 1'b1);
    while (!((s == 0) ? i_done_o : d_done_o)) begin
      @(negedge clk_i);
      cyc++;
      expect_busy(s, 1'b1); // held through the done cycle
    end
    g_ppn = (s == 0) ? i_ppn_o : d_ppn_o;
    g_sp  = (s == 0) ? i_superpage_o : d_superpage_o;
    g_flt = (s == 0) ? i_fault_o : d_fault_o;
    assert (g_flt == e_flt) else report_mismatch({sn, "_fault_o"}, e_flt, g_flt);
    assert (g_sp == e_sp) else report_mismatch({sn, "_superpage_o"}, e_sp, g_sp);
    if (!e_flt) begin
      assert (g_ppn == e_ppn) else report_mismatch({sn, "_ppn_o"}, e_ppn, g_ppn);
    end
    if (solo) begin // two cycles per table read without competition
      assert (cyc == 2 * nrd) else report_mismatch({sn, "_done_o latency"}, 2 * nrd, cyc);
    end
  endtask

  task automatic run_side(input int s, input int n, input bit solo);
    int gap;
    for (int k = 0; k < n; k++) begin
      gap = {$random(seed)} % 3;
      repeat (gap) @(posedge clk_i);
      translate(s, pick_vpn(), solo);
    end
  endtask

  // each done_o closes exactly one issued walk
  always @(negedge clk_i) begin
    if (i_done_o) begin
      assert (pending[0]) else fail_run("i-side done_o pulsed with no walk outstanding");
      pending[0] = 1'b0;
    end
    if (d_done_o) begin
      assert (pending[1]) else fail_run("d-side done_o pulsed with no walk outstanding");
      pending[1] = 1'b0;
    end
  end

  initial begin
    #(WD_CYCLES * 20);
    fail_run("watchdog expired before all walks completed");
  end

  initial begin
    logic [31:0] r;
    seed = 32'h6dce_9be2;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    pt_we_i = 1'b0;
    pt_waddr_i = '0;
    pt_wdata_i = '0;
    i_req_i = 1'b0;
    i_vpn_i = '0;
    d_req_i = 1'b0;
    d_vpn_i = '0;
    for (int k = 0; k < 10; k++) begin // small pools so vpns repeat
      r = $random(seed);
      if (k < 6) vpn2_pool[k] = r[memory_pkg::VPN_PART_LEN-1:0];
      else       vpn1_pool[k-6] = r[memory_pkg::VPN_PART_LEN-1:0];
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!i_busy_o && !d_busy_o && !i_done_o && !d_done_o)
      else fail_run("walker busy or done output not low after reset");
    write_tables();
    run_side(0, N_SOLO, 1'b1);
    run_side(1, N_SOLO, 1'b1);
    fork
      run_side(0, N_DUAL, 1'b0);
      run_side(1, N_DUAL, 1'b0);
    join
    write_tables(); // cached pointers go stale without a flush
    fork
      run_side(0, N_DUAL, 1'b0);
      run_side(1, N_DUAL, 1'b0);
    join
    flush_caches();
    run_side(0, N_SOLO, 1'b1);
    run_side(1, N_SOLO, 1'b1);
    fork
      run_side(0, N_DUAL, 1'b0);
      run_side(1, N_DUAL, 1'b0);
    join
    repeat (4) @(posedge clk_i);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: compile.f
memory_pkg.sv
tpc_regfile.sv
tpc_comp_block.sv
mmu_cache.sv
ptw.sv
pt_arbiter.sv
pt_mem.sv
ptw_top.sv
tb_ptw_top.sv
